//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
LINTFLAGS  ?= --lint-only --timing -Wall
TOP        ?= dMemSsTb
FILELIST   ?= verilog.f
LOG        ?= sim.log
PASS_MSG   ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- design/crMem.sv
`timescale 1ns/10ps

module crMem (
   input  logic        Clock,
   input  logic        rstN,
   input  logic        en,
   input  logic        wr,
   input  logic [13:0] wordAddr,
   input  logic [31:0] wrData,
   output logic [31:0] rdWord,
   input  logic [15:0] switches,
   output logic [15:0] led,
   input  logic [7:0]  kbdData,
   input  logic        kbdValid,
   output logic        kbdPop,
   input  logic [9:0]  scanX,
   input  logic [9:0]  scanY
);
   import crPkg::*;

   tCrAddr      crAddr;
   logic [31:0] scratch;
   logic [7:0]  kbdByte;
   logic        kbdPending;
   logic        kbdRead;
   logic        kbdLatch;

   // region holds 16 words
   assign crAddr   = tCrAddr'(wordAddr[3:0]);
   assign kbdRead  = en && !wr && (crAddr == CR_KBD_DATA);
   // next byte only once the last one was taken
   assign kbdLatch = !kbdPending && kbdValid;

   // ========================================
   // writable state and keyboard flag
   // ========================================

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         scratch    <= '0;
         led        <= '0;
         kbdPending <= 1'b0;
         kbdPop     <= 1'b0;
      end else begin
         kbdPop <= kbdRead;
         if (en && wr) begin
            case (crAddr)
               CR_SCRATCH: scratch <= wrData;
               CR_LED:     led     <= wrData[15:0];
               default:    ;
            endcase
         end
         if (kbdRead) kbdPending <= 1'b0;
         // latch takes priority over clear
         if (kbdLatch) kbdPending <= 1'b1;
      end
   end

   always_ff @(posedge Clock) begin
      if (kbdLatch) kbdByte <= kbdData;
      // read port, one cycle latency
      if (en && !wr) begin
         case (crAddr)
            CR_SCRATCH:    rdWord <= scratch;
            CR_LED:        rdWord <= {16'b0, led};
            CR_SWITCH:     rdWord <= {16'b0, switches};
            CR_KBD_DATA:   rdWord <= {24'b0, kbdByte};
            CR_KBD_STATUS: rdWord <= {31'b0, kbdPending};
            CR_VGA_X:      rdWord <= {22'b0, scanX};
            CR_VGA_Y:      rdWord <= {22'b0, scanY};
            default:       rdWord <= '0;
         endcase
      end
   end

endmodule

//--- design/crPkg.sv
package crPkg;

   // word offsets inside the control-register region
   typedef enum logic [3:0] {
      CR_SCRATCH,
      CR_LED,
      CR_SWITCH,
      CR_KBD_DATA,
      CR_KBD_STATUS,
      CR_VGA_X,
      CR_VGA_Y
   } tCrAddr;

   // ========================================
   // 640x480 scan timing
   // ========================================

   // horizontal, in clocks
   localparam logic [9:0] H_ACTIVE     = 10'd640;
   localparam logic [9:0] H_TOTAL      = 10'd800;
   localparam logic [9:0] H_SYNC_START = 10'd656;
   localparam logic [9:0] H_SYNC_LEN   = 10'd96;
   // vertical, in lines
   localparam logic [9:0] V_ACTIVE     = 10'd480;
   localparam logic [9:0] V_TOTAL      = 10'd525;
   localparam logic [9:0] V_SYNC_START = 10'd490;
   localparam logic [9:0] V_SYNC_LEN   = 10'd2;

endpackage

//--- design/dMemCtrl.sv
`timescale 1ns/10ps

module dMemCtrl (
   input  logic        Clock,
   input  logic        rstN,
   input  logic        rdEn,
   input  logic        wrEn,
   input  logic        signExt,
   input  logic [31:0] address,
   input  logic [31:0] wrData,
   input  logic [3:0]  byteEn,
   output logic        ready,
   output logic        rdValid,
   output logic [31:0] rdData,
   output logic        dataEn,
   output logic        crEn,
   output logic        vgaEn,
   output logic        blockWr,
   output logic [13:0] wordAddr,
   output logic [31:0] blockWrData,
   output logic [3:0]  blockByteEn,
   input  logic [31:0] dataRdWord,
   input  logic [31:0] crRdWord,
   input  logic [31:0] vgaRdWord,
   input  logic        fetchBusy
);
   import dMemPkg::*;

   tDMemOp      op;
   tRegion      region;
   logic [31:0] regionFloor;
   logic [31:0] offsetAddr;
   logic        accept;
   logic        rdAccept;
   // stage 1 state
   logic        s1Valid;
   tRegion      s1Region;
   logic [1:0]  s1Offset;
   logic [3:0]  s1ByteEn;
   logic        s1SignExt;
   // read merge path
   logic [31:0] rawWord;
   logic [31:0] shiftWord;
   logic [31:0] alignWord;

   // ========================================
   // request decode
   // ========================================

   // write wins if both are raised
   always_comb begin
      if (wrEn) op = OP_WR;
      else if (rdEn) op = OP_RD;
      else op = OP_NONE;
   end

   always_comb begin
      region      = REG_NONE;
      regionFloor = '0;
      if (address >= DATA_FLOOR && address <= DATA_CEIL) begin
         region      = REG_DATA;
         regionFloor = DATA_FLOOR;
      end else if (address >= CR_FLOOR && address <= CR_CEIL) begin
         region      = REG_CR;
         regionFloor = CR_FLOOR;
      end else if (address >= VGA_FLOOR && address <= VGA_CEIL) begin
         region      = REG_VGA;
         regionFloor = VGA_FLOOR;
      end
   end

   // word index inside the region
   assign offsetAddr = address - regionFloor;
   assign wordAddr   = offsetAddr[15:2];

   // frame buffer port is taken by a display fetch
   assign ready    = !((op != OP_NONE) && (region == REG_VGA) && fetchBusy);
   assign accept   = (op != OP_NONE) && ready;
   assign rdAccept = accept && (op == OP_RD);

   // unmapped hits raise no enable, so writes there vanish
   assign dataEn      = accept && (region == REG_DATA);
   assign crEn        = accept && (region == REG_CR);
   assign vgaEn       = accept && (region == REG_VGA);
   assign blockWr     = (op == OP_WR);
   // store lanes already placed by the core
   assign blockWrData = wrData;
   assign blockByteEn = byteEn;

   // ========================================
   // stage 1, read bookkeeping
   // ========================================

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) s1Valid <= 1'b0;
      else s1Valid <= rdAccept;
   end

   always_ff @(posedge Clock) begin
      if (rdAccept) begin
         s1Region  <= region;
         s1Offset  <= address[1:0];
         s1ByteEn  <= byteEn;
         s1SignExt <= signExt;
      end
   end

   // pick the block word, bring the lane down, trim and extend
   always_comb begin
      case (s1Region)
         REG_DATA: rawWord = dataRdWord;
         REG_CR:   rawWord = crRdWord;
         REG_VGA:  rawWord = vgaRdWord;
         default:  rawWord = '0;
      endcase
      shiftWord = rawWord >> {s1Offset, 3'b000};
      case (s1ByteEn)
         4'b0001, 4'b0010, 4'b0100, 4'b1000:
            alignWord = {{24{s1SignExt & shiftWord[7]}}, shiftWord[7:0]};
         4'b0011, 4'b1100:
            alignWord = {{16{s1SignExt & shiftWord[15]}}, shiftWord[15:0]};
         default:
            alignWord = shiftWord;
      endcase
   end

   // ========================================
   // stage 2, response to core
   // ========================================

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) rdValid <= 1'b0;
      else rdValid <= s1Valid;
   end

   always_ff @(posedge Clock) begin
      if (s1Valid) rdData <= alignWord;
   end

endmodule

//--- design/dMemPkg.sv
package dMemPkg;

   // ========================================
   // request and region kinds
   // ========================================

   // decoded kind of core request
   typedef enum logic [1:0] {
      OP_NONE,
      OP_RD,
      OP_WR
   } tDMemOp;

   // region hit by the request address
   typedef enum logic [1:0] {
      REG_DATA,
      REG_CR,
      REG_VGA,
      REG_NONE
   } tRegion;

   // ========================================
   // address map
   // ========================================

   // data ram, 4 KiB of bytes
   localparam logic [31:0] DATA_FLOOR = 32'h0001_0000;
   localparam logic [31:0] DATA_CEIL  = 32'h0001_0FFF;
   // control registers, 16 words
   localparam logic [31:0] CR_FLOOR   = 32'h0002_0000;
   localparam logic [31:0] CR_CEIL    = 32'h0002_003F;
   // frame buffer, one bit per pixel
   localparam logic [31:0] VGA_FLOOR  = 32'h0003_0000;
   localparam logic [31:0] VGA_CEIL   = 32'h0003_95FF;

   // depths in words
   localparam int DATA_WORDS = 1024;
   localparam int VGA_WORDS  = 9600;

endpackage

//--- design/dMemSs.sv
`timescale 1ns/10ps

module dMemSs (
   input  logic        Clock,
   input  logic        rstN,
   // ========================================
   // core request and response
   // ========================================
   input  logic        rdEn,
   input  logic        wrEn,
   input  logic [31:0] address,
   input  logic [31:0] wrData,
   input  logic [3:0]  byteEn,
   input  logic        signExt,
   output logic        ready,
   output logic        rdValid,
   output logic [31:0] rdData,
   // board io
   input  logic [15:0] switches,
   output logic [15:0] led,
   // keyboard
   input  logic [7:0]  kbdData,
   input  logic        kbdValid,
   output logic        kbdPop,
   // display
   output logic        hSync,
   output logic        vSync,
   output logic        inDisplayArea,
   output logic        pixel
);

   logic        dataEn;
   logic        crEn;
   logic        vgaEn;
   logic        blockWr;
   logic [13:0] wordAddr;
   logic [31:0] blockWrData;
   logic [3:0]  blockByteEn;
   logic [31:0] dataRdWord;
   logic [31:0] crRdWord;
   logic [31:0] vgaRdWord;
   logic        fetchBusy;
   // scan position for the register block
   logic [9:0]  scanX;
   logic [9:0]  scanY;

   dMemCtrl dMemCtrl (
      .Clock       (Clock),
      .rstN        (rstN),
      .rdEn        (rdEn),
      .wrEn        (wrEn),
      .signExt     (signExt),
      .address     (address),
      .wrData      (wrData),
      .byteEn      (byteEn),
      .ready       (ready),
      .rdValid     (rdValid),
      .rdData      (rdData),
      .dataEn      (dataEn),
      .crEn        (crEn),
      .vgaEn       (vgaEn),
      .blockWr     (blockWr),
      .wordAddr    (wordAddr),
      .blockWrData (blockWrData),
      .blockByteEn (blockByteEn),
      .dataRdWord  (dataRdWord),
      .crRdWord    (crRdWord),
      .vgaRdWord   (vgaRdWord),
      .fetchBusy   (fetchBusy)
   );

   dataRam dataRam (
      .Clock    (Clock),
      .en       (dataEn),
      .wr       (blockWr),
      .wordAddr (wordAddr),
      .wrData   (blockWrData),
      .byteEn   (blockByteEn),
      .rdWord   (dataRdWord)
   );

   crMem crMem (
      .Clock    (Clock),
      .rstN     (rstN),
      .en       (crEn),
      .wr       (blockWr),
      .wordAddr (wordAddr),
      .wrData   (blockWrData),
      .rdWord   (crRdWord),
      .switches (switches),
      .led      (led),
      .kbdData  (kbdData),
      .kbdValid (kbdValid),
      .kbdPop   (kbdPop),
      .scanX    (scanX),
      .scanY    (scanY)
   );

   vgaCtrl vgaCtrl (
      .Clock         (Clock),
      .rstN          (rstN),
      .en            (vgaEn),
      .wr            (blockWr),
      .wordAddr      (wordAddr),
      .wrData        (blockWrData),
      .byteEn        (blockByteEn),
      .rdWord        (vgaRdWord),
      .fetchBusy     (fetchBusy),
      .hSync         (hSync),
      .vSync         (vSync),
      .inDisplayArea (inDisplayArea),
      .pixel         (pixel),
      .scanX         (scanX),
      .scanY         (scanY)
   );

endmodule

//--- design/dataRam.sv
`timescale 1ns/10ps

module dataRam (
   input  logic        Clock,
   input  logic        en,
   input  logic        wr,
   input  logic [13:0] wordAddr,
   input  logic [31:0] wrData,
   input  logic [3:0]  byteEn,
   output logic [31:0] rdWord
);
   import dMemPkg::*;

   logic [31:0]                   mem [DATA_WORDS];
   logic [$clog2(DATA_WORDS)-1:0] ramIdx;

   // region decode keeps the upper index bits at zero
   assign ramIdx = wordAddr[$clog2(DATA_WORDS)-1:0];

   // ========================================
   // single port, byte lanes
   // ========================================

   always_ff @(posedge Clock) begin
      if (en) begin
         if (wr) begin
            // one lane per byte enable
            for (int b = 0; b < 4; b++) begin
               if (byteEn[b]) mem[ramIdx][8*b +: 8] <= wrData[8*b +: 8];
            end
         end else begin
            // registered read, raw word
            rdWord <= mem[ramIdx];
         end
      end
   end

endmodule

//--- design/vgaCtrl.sv
`timescale 1ns/10ps

module vgaCtrl (
   input  logic        Clock,
   input  logic        rstN,
   input  logic        en,
   input  logic        wr,
   input  logic [13:0] wordAddr,
   input  logic [31:0] wrData,
   input  logic [3:0]  byteEn,
   output logic [31:0] rdWord,
   output logic        fetchBusy,
   output logic        hSync,
   output logic        vSync,
   output logic        inDisplayArea,
   output logic        pixel,
   output logic [9:0]  scanX,
   output logic [9:0]  scanY
);
   import crPkg::*;
   import dMemPkg::*;

   logic [31:0] fbMem [VGA_WORDS];
   logic [9:0]  hCount;
   logic [9:0]  vCount;
   logic        active;
   logic [13:0] fetchAddr;
   logic [13:0] portAddr;
   logic [31:0] fbRd;
   logic [31:0] pixWord;
   logic        fetchQ;
   logic        dispQ1;
   logic        dispQ2;
   logic [4:0]  idxQ1;
   logic [4:0]  idxQ2;

   // ========================================
   // scan counters and sync
   // ========================================

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         hCount <= '0;
         vCount <= '0;
         hSync  <= 1'b1;
         vSync  <= 1'b1;
      end else begin
         if (hCount == H_TOTAL - 10'd1) begin
            hCount <= '0;
            if (vCount == V_TOTAL - 10'd1) vCount <= '0;
            else vCount <= vCount + 10'd1;
         end else begin
            hCount <= hCount + 10'd1;
         end
         // active low inside the sync windows
         hSync <= !(hCount >= H_SYNC_START && hCount < H_SYNC_START + H_SYNC_LEN);
         vSync <= !(vCount >= V_SYNC_START && vCount < V_SYNC_START + V_SYNC_LEN);
      end
   end

   assign scanX     = hCount;
   assign scanY     = vCount;
   assign active    = (hCount < H_ACTIVE) && (vCount < V_ACTIVE);
   // display owns the port every fourth active clock
   assign fetchBusy = active && (hCount[1:0] == 2'b00);
   // 20 words per line, y*16 + y*4 + x/32
   assign fetchAddr = {vCount, 4'b0000} + {2'b00, vCount, 2'b00} + {9'b0, hCount[9:5]};
   assign portAddr  = fetchBusy ? fetchAddr : wordAddr;

   // ========================================
   // frame buffer, shared single port
   // ========================================

   always_ff @(posedge Clock) begin
      if (en && wr) begin
         for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) fbMem[wordAddr][8*b +: 8] <= wrData[8*b +: 8];
         end
      end
      if (fetchBusy || (en && !wr)) fbRd <= fbMem[portAddr];
      // hold the fetched word for the next four pixels
      if (fetchQ) pixWord <= fbRd;
      idxQ1 <= hCount[4:0];
      idxQ2 <= idxQ1;
   end

   assign rdWord = fbRd;

   // pixel pipeline is two clocks behind the counters
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         fetchQ <= 1'b0;
         dispQ1 <= 1'b0;
         dispQ2 <= 1'b0;
      end else begin
         fetchQ <= fetchBusy;
         dispQ1 <= active;
         dispQ2 <= dispQ1;
      end
   end

   assign inDisplayArea = dispQ2;
   assign pixel         = dispQ2 & pixWord[idxQ2];

endmodule

//--- tests/dMemSsTb.sv
`timescale 1ns/10ps

module dMemSsTb;
   import dMemPkg::*;
   import crPkg::*;

   // frame buffer words between two test writes, and words per scan line
   localparam int FB_STRIDE  = 37;
   localparam int LINE_WORDS = int'(H_ACTIVE) / 32;

   // one core request and, for reads, the word the core should get back
   typedef struct packed {
      tDMemOp      op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  be;
      logic        sx;
      logic [31:0] expected;
   } tEntry;

   logic        Clock;
   logic        rstN;
   logic        rdEn;
   logic        wrEn;
   logic [31:0] address;
   logic [31:0] wrData;
   logic [3:0]  byteEn;
   logic        signExt;
   logic        ready;
   logic        rdValid;
   logic [31:0] rdData;
   logic [15:0] switches;
   logic [15:0] led;
   logic [7:0]  kbdData;
   logic        kbdValid;
   logic        kbdPop;
   logic        hSync;
   logic        vSync;
   logic        inDisplayArea;
   logic        pixel;

   tEntry       stimTable[$];
   // reads in flight, oldest first
   logic [31:0] expQ[$];
   logic [31:0] expAddrQ[$];
   // words written to the frame buffer, FB_STRIDE apart
   logic [31:0] fbWords [8];
   int          seed;
   int          cycle = 0;
   int          limit = 0;
   int          stallCount;
   int          popCount;
   int          kbdStart;
   int          vgaStart;
   // position inside the shown area
   int          pixX = 0;
   int          pixY = 0;
   int          pixChecks = 0;

   dMemSs UUT (
      .Clock         (Clock),
      .rstN          (rstN),
      .rdEn          (rdEn),
      .wrEn          (wrEn),
      .address       (address),
      .wrData        (wrData),
      .byteEn        (byteEn),
      .signExt       (signExt),
      .ready         (ready),
      .rdValid       (rdValid),
      .rdData        (rdData),
      .switches      (switches),
      .led           (led),
      .kbdData       (kbdData),
      .kbdValid      (kbdValid),
      .kbdPop        (kbdPop),
      .hSync         (hSync),
      .vSync         (vSync),
      .inDisplayArea (inDisplayArea),
      .pixel         (pixel)
   );

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   // ========================================
   // failure reporting and compares
   // ========================================

   task automatic abortRun(string line);
      $display("%s", line);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic checkWord(string what, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
         abortRun($sformatf("** Error at %0t ns: %s got 0x%08h expected 0x%08h",
                            $time, what, got, exp));
   endtask

   task automatic checkLed(string what, logic [15:0] got, logic [15:0] exp);
      if (got !== exp)
         abortRun($sformatf("** Error at %0t ns: %s got 0x%04h expected 0x%04h",
                            $time, what, got, exp));
   endtask

   task automatic checkSync(string what, logic [9:0] got, logic [9:0] exp);
      if (got !== exp)
         abortRun($sformatf("** Error at %0t ns: %s got %0d cycles expected %0d",
                            $time, what, got, exp));
   endtask

   task automatic checkLevel(string what, logic got, logic exp);
      if (got !== exp)
         abortRun($sformatf("** Error at %0t ns: %s got %b expected %b",
                            $time, what, got, exp));
   endtask

   // cycle limit for the whole run
   always @(posedge Clock) begin
      cycle <= cycle + 1;
      if (limit != 0 && cycle >= limit)
         abortRun($sformatf("timeout: run still busy after %0d cycles", cycle));
   end

   // sampled on the falling edge, away from the DUT's updates
   always @(negedge Clock) begin
      if (kbdPop) popCount++;
      if (rdValid) begin
         if (expQ.size() == 0)
            abortRun("read data came back while no read was outstanding");
         else
            checkWord($sformatf("read of 0x%08h", expAddrQ.pop_front()), rdData,
                      expQ.pop_front());
      end
   end

   // shown pixels, word y*20 + x/32, leftmost pixel in bit 0
   always @(negedge Clock) begin : displayMon
      int fbIdx;
      if (rstN === 1'b1) begin
         // no vertical sync in the first lines of a frame
         checkLevel("vSync outside its sync lines", vSync, 1'b1);
         if (inDisplayArea === 1'b1) begin
            fbIdx = pixY * LINE_WORDS + pixX / 32;
            // line 0 is shown before the writes land
            if (pixY > 0 && fbIdx % FB_STRIDE == 0 && fbIdx / FB_STRIDE < 8) begin
               checkLevel($sformatf("pixel at x %0d line %0d", pixX, pixY), pixel,
                          fbWords[fbIdx / FB_STRIDE][pixX % 32]);
               pixChecks++;
            end
            pixX++;
         end else if (pixX != 0) begin
            pixX = 0;
            pixY++;
         end
      end
   end

   // ========================================
   // stimulus table
   // ========================================

   function automatic void addEntry(tDMemOp op, logic [31:0] addr, logic [31:0] data,
                                    logic [3:0] be, logic sx, logic [31:0] expected);
      tEntry e;
      e.op       = op;
      e.addr     = addr;
      e.data     = data;
      e.be       = be;
      e.sx       = sx;
      e.expected = expected;
      stimTable.push_back(e);
   endfunction

   function automatic logic [31:0] crAddress(tCrAddr r);
      return CR_FLOOR + {26'b0, r, 2'b00};
   endfunction

   task automatic buildTable();
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      // data ram, whole words then one byte lane
      addEntry(OP_WR, DATA_FLOOR + 32'h010, r1, 4'b1111, 1'b0, '0);
      addEntry(OP_WR, DATA_FLOOR + 32'h7FC, r2, 4'b1111, 1'b0, '0);
      addEntry(OP_RD, DATA_FLOOR + 32'h010, '0, 4'b1111, 1'b0, r1);
      addEntry(OP_RD, DATA_FLOOR + 32'h7FC, '0, 4'b1111, 1'b0, r2);
      addEntry(OP_WR, DATA_FLOOR + 32'h040, 32'h1234_5678, 4'b1111, 1'b0, '0);
      addEntry(OP_WR, DATA_FLOOR + 32'h042, 32'h009C_0000, 4'b0100, 1'b0, '0);
      addEntry(OP_RD, DATA_FLOOR + 32'h042, '0, 4'b0100, 1'b1, 32'hFFFF_FF9C);
      addEntry(OP_RD, DATA_FLOOR + 32'h042, '0, 4'b0100, 1'b0, 32'h0000_009C);
      addEntry(OP_RD, DATA_FLOOR + 32'h040, '0, 4'b1111, 1'b0, 32'h129C_5678);
      addEntry(OP_RD, DATA_FLOOR + 32'h042, '0, 4'b1100, 1'b1, 32'h0000_129C);
      // control registers
      addEntry(OP_WR, crAddress(CR_SCRATCH), r3, 4'b1111, 1'b0, '0);
      addEntry(OP_RD, crAddress(CR_SCRATCH), '0, 4'b1111, 1'b0, r3);
      addEntry(OP_WR, crAddress(CR_LED), 32'h0000_A5C3, 4'b1111, 1'b0, '0);
      addEntry(OP_RD, crAddress(CR_LED), '0, 4'b1111, 1'b0, 32'h0000_A5C3);
      addEntry(OP_RD, crAddress(CR_SWITCH), '0, 4'b1111, 1'b0, {16'b0, switches});
      // nothing mapped here
      addEntry(OP_WR, 32'h0004_0000, r1, 4'b1111, 1'b0, '0);
      addEntry(OP_RD, 32'h0005_0000, '0, 4'b1111, 1'b0, '0);
      addEntry(OP_RD, 32'h0000_0100, '0, 4'b1111, 1'b0, '0);
      // keyboard, status then data then status
      kbdStart = stimTable.size();
      addEntry(OP_RD, crAddress(CR_KBD_STATUS), '0, 4'b1111, 1'b0, 32'd1);
      addEntry(OP_RD, crAddress(CR_KBD_DATA), '0, 4'b1111, 1'b0, 32'h0000_005A);
      addEntry(OP_RD, crAddress(CR_KBD_STATUS), '0, 4'b1111, 1'b0, 32'd0);
      // frame buffer, long enough to run into fetch cycles
      vgaStart = stimTable.size();
      for (int k = 0; k < 8; k++) begin
         fbWords[k] = $random(seed);
         addEntry(OP_WR, VGA_FLOOR + 32'(k * FB_STRIDE * 4), fbWords[k], 4'b1111, 1'b0,
                  '0);
      end
      for (int k = 0; k < 8; k++)
         addEntry(OP_RD, VGA_FLOOR + 32'(k * FB_STRIDE * 4), '0, 4'b1111, 1'b0,
                  fbWords[k]);
   endtask

   // ========================================
   // request driver
   // ========================================

   // called on a rising edge, returns on the edge that accepts the request
   task automatic applyEntry(tEntry e);
      rdEn    <= (e.op == OP_RD);
      wrEn    <= (e.op == OP_WR);
      address <= e.addr;
      wrData  <= e.data;
      byteEn  <= e.be;
      signExt <= e.sx;
      @(negedge Clock);
      // held unchanged while the frame buffer port is busy
      while (!ready) begin
         stallCount++;
         @(negedge Clock);
      end
      if (e.op == OP_RD) begin
         expQ.push_back(e.expected);
         expAddrQ.push_back(e.addr);
      end
      @(posedge Clock);
   endtask

   task automatic runEntries(int first, int last);
      for (int i = first; i < last; i++) applyEntry(stimTable[i]);
      rdEn <= 1'b0;
      wrEn <= 1'b0;
   endtask

   task automatic drainReads();
      while (expQ.size() != 0) @(negedge Clock);
      @(posedge Clock);
   endtask

   // low width and full period of hSync, and shown clocks in that line
   task automatic measureHSync(output int width, output int period, output int shown);
      int n;
      int s;
      n = 0;
      s = 0;
      @(negedge Clock);
      while (hSync !== 1'b1) @(negedge Clock);
      while (hSync !== 1'b0) @(negedge Clock);
      while (hSync === 1'b0) begin
         n++;
         if (inDisplayArea === 1'b1) s++;
         @(negedge Clock);
      end
      width = n;
      while (hSync === 1'b1) begin
         n++;
         if (inDisplayArea === 1'b1) s++;
         @(negedge Clock);
      end
      period = n;
      shown  = s;
   endtask

   // ========================================
   // main sequence
   // ========================================

   initial begin : mainSeq
      int width;
      int period;
      int shown;
      seed     = 88;
      rstN     = 1'b0;
      rdEn     = 1'b0;
      wrEn     = 1'b0;
      address  = '0;
      wrData   = '0;
      byteEn   = '0;
      signExt  = 1'b0;
      kbdData  = '0;
      kbdValid = 1'b0;
      switches = 16'($random(seed));
      buildTable();
      limit = stimTable.size() * 8 + 2 * int'(H_TOTAL) * 2;
      repeat (16) @(posedge Clock);
      rstN <= 1'b1;
      @(posedge Clock);
      // data ram, registers, unmapped
      runEntries(0, kbdStart);
      drainReads();
      checkLed("led after LED register write", led, 16'hA5C3);
      // one keyboard byte
      popCount = 0;
      kbdData  <= 8'h5A;
      kbdValid <= 1'b1;
      @(posedge Clock);
      kbdValid <= 1'b0;
      runEntries(kbdStart, vgaStart);
      drainReads();
      checkWord("kbdPop pulse count", 32'(popCount), 32'd1);
      // frame buffer under fetch back-pressure
      stallCount = 0;
      runEntries(vgaStart, stimTable.size());
      drainReads();
      if (stallCount == 0)
         abortRun("no frame buffer access ever saw ready low, fetch stall not exercised");
      measureHSync(width, period, shown);
      checkSync("hSync low width", 10'(width), H_SYNC_LEN);
      checkSync("hSync period", 10'(period), H_TOTAL);
      checkSync("display area width", 10'(shown), H_ACTIVE);
      if (pixChecks < 32)
         abortRun("a written frame buffer word never reached the display");
      $display("RESULT: PASS");
      $finish;
   end

endmodule

//--- verilog.f
design/dMemPkg.sv
design/crPkg.sv
design/dMemCtrl.sv
design/dataRam.sv
design/crMem.sv
design/vgaCtrl.sv
design/dMemSs.sv
tests/dMemSsTb.sv
